/* Bender.yml */
package:
  name: execute_stage

sources:
  - hdl/exec_ops_pkg.sv
  - hdl/mem_access_pkg.sv
  - hdl/int_result_if.sv
  - hdl/mem_req_if.sv
  - hdl/integer_unit.sv
  - hdl/mem_access_unit.sv
  - hdl/retire_control.sv
  - hdl/execute_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_execute_stage.sv

/* hdl/exec_ops_pkg.sv */
package exec_ops_pkg;

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    localparam int unsigned xlen       = 32;
    localparam int unsigned shamt_bits = $clog2(xlen);

    // Instruction sizes in bytes, used for the link value
    localparam int unsigned inst_bytes            = 4;
    localparam int unsigned compressed_inst_bytes = 2;

    ////////////////////////////////////////
    // Operations
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        LUI,
        ADD, SUB,
        SLT, SLTU,
        XOR, OR, AND,
        SLL, SRL, SRA,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ECALL,
        EBREAK
    } op_e;

    // Current privilege, as encoded by the privileged spec
    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // Synchronous exception causes
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        LOAD_ACCESS_FAULT              = 4'd5,
        ECALL_FROM_UMODE               = 4'd8,
        ECALL_FROM_MMODE               = 4'd11,
        NO_EXCEPTION                   = 4'd15
    } exc_code_e;

endpackage

/* hdl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import exec_ops_pkg::*;
    import mem_access_pkg::*;
#(
    parameter int unsigned TAG_WIDTH = 3
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 stall_i,
    input  logic [xlen-1:0]      pc_i,
    input  logic [xlen-1:0]      first_operand_i,
    input  logic [xlen-1:0]      second_operand_i,
    input  logic [xlen-1:0]      third_operand_i,
    input  op_e                  operation_i,
    input  logic                 compressed_i,
    input  logic [TAG_WIDTH-1:0] tag_i,
    input  priv_e                privilege_i,
    input  logic                 exc_illegal_inst_i,
    input  logic                 exc_misaligned_fetch_i,
    input  logic                 exc_load_access_fault_i,

    output logic                 killed_o,
    output logic                 jump_o,
    output logic [xlen-1:0]      jump_target_o,
    output logic [xlen-1:0]      mem_address_o,
    output logic                 mem_read_enable_o,
    output byte_en_t             mem_write_enable_o,
    output logic [xlen-1:0]      mem_write_data_o,
    output logic                 raise_exception_o,
    output exc_code_e            exception_code_o,
    output logic                 write_enable_o,
    output op_e                  operation_o,
    output logic [xlen-1:0]      result_o
);

    int_result_if int_res ();
    mem_req_if    mem_req ();

    integer_unit i_integer_unit (
        .pc_i             (pc_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .third_operand_i  (third_operand_i),
        .operation_i      (operation_i),
        .compressed_i     (compressed_i),
        .res              (int_res)
    );

    mem_access_unit i_mem_access_unit (
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .third_operand_i  (third_operand_i),
        .operation_i      (operation_i),
        .req              (mem_req)
    );

    retire_control #(
        .TAG_WIDTH (TAG_WIDTH)
    ) i_retire_control (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .operation_i             (operation_i),
        .tag_i                   (tag_i),
        .privilege_i             (privilege_i),
        .exc_illegal_inst_i      (exc_illegal_inst_i),
        .exc_misaligned_fetch_i  (exc_misaligned_fetch_i),
        .exc_load_access_fault_i (exc_load_access_fault_i),
        .res                     (int_res),
        .req                     (mem_req),
        .killed_o                (killed_o),
        .jump_o                  (jump_o),
        .raise_exception_o       (raise_exception_o),
        .exception_code_o        (exception_code_o),
        .write_enable_o          (write_enable_o),
        .operation_o             (operation_o),
        .result_o                (result_o)
    );

    // Memory side goes straight out, stall does not gate it
    assign jump_target_o      = int_res.jump_target;
    assign mem_address_o      = mem_req.address;
    assign mem_read_enable_o  = mem_req.read_enable;
    assign mem_write_enable_o = mem_req.write_enable;
    assign mem_write_data_o   = mem_req.write_data;

endmodule

/* hdl/int_result_if.sv */
`timescale 1ns/100ps

interface int_result_if
    import exec_ops_pkg::*;
();

    logic [xlen-1:0] value;
    // Raw decision, before the kill check
    logic            take_branch;
    logic [xlen-1:0] jump_target;
    logic [xlen-1:0] link_value;

    modport source (
        output value, take_branch, jump_target, link_value
    );

    modport sink (
        input value, take_branch, jump_target, link_value
    );

endinterface

/* hdl/integer_unit.sv */
`timescale 1ns/100ps

module integer_unit
    import exec_ops_pkg::*;
(
    input  logic [xlen-1:0] pc_i,
    input  logic [xlen-1:0] first_operand_i,
    input  logic [xlen-1:0] second_operand_i,
    input  logic [xlen-1:0] third_operand_i,
    input  op_e             operation_i,
    input  logic            compressed_i,
    int_result_if.source    res
);

    logic signed [xlen-1:0] first_signed;
    logic signed [xlen-1:0] second_signed;
    logic [shamt_bits-1:0]  shamt;
    logic [xlen-1:0]        sum;
    logic [xlen-1:0]        difference;
    logic                   equal;
    logic                   less_than;
    logic                   less_than_unsigned;

    assign first_signed  = first_operand_i;
    assign second_signed = second_operand_i;

    // Only the low bits of rs2 give the shift amount
    assign shamt = second_operand_i[shamt_bits-1:0];

    assign sum        = first_operand_i + second_operand_i;
    assign difference = first_operand_i - second_operand_i;

    assign equal              = first_operand_i == second_operand_i;
    assign less_than          = first_signed < second_signed;
    assign less_than_unsigned = first_operand_i < second_operand_i;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            LUI:     res.value = second_operand_i;
            SUB:     res.value = difference;
            SLT:     res.value = xlen'(less_than);
            SLTU:    res.value = xlen'(less_than_unsigned);
            XOR:     res.value = first_operand_i ^ second_operand_i;
            OR:      res.value = first_operand_i | second_operand_i;
            AND:     res.value = first_operand_i & second_operand_i;
            SLL:     res.value = first_operand_i << shamt;
            SRL:     res.value = first_operand_i >> shamt;
            SRA:     res.value = first_signed >>> shamt;
            default: res.value = sum;
        endcase
    end

    ////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            BEQ:       res.take_branch = equal;
            BNE:       res.take_branch = !equal;
            BLT:       res.take_branch = less_than;
            BGE:       res.take_branch = !less_than;
            BLTU:      res.take_branch = less_than_unsigned;
            BGEU:      res.take_branch = !less_than_unsigned;
            JAL, JALR: res.take_branch = 1'b1;
            default:   res.take_branch = 1'b0;
        endcase
    end

    // Conditional branches use the immediate in the third operand
    always_comb begin
        unique case (operation_i)
            JAL:     res.jump_target = sum;
            JALR:    res.jump_target = {sum[xlen-1:1], 1'b0};
            default: res.jump_target = pc_i + third_operand_i;
        endcase
    end

    // Return address skips a 16 or 32 bit instruction
    assign res.link_value = pc_i + (compressed_i ? xlen'(compressed_inst_bytes)
                                                 : xlen'(inst_bytes));

    jalr_target_aligned: assert final (operation_i != JALR || !res.jump_target[0])
        else $error("JALR target has bit 0 set");

endmodule

/* hdl/mem_access_pkg.sv */
package mem_access_pkg;

    ////////////////////////////////////////
    // Word layout
    ////////////////////////////////////////

    // Low address bits that pick a byte inside a word
    localparam int unsigned word_offset_bits = 2;
    localparam int unsigned bytes_per_word   = 1 << word_offset_bits;
    localparam int unsigned halves_per_word  = bytes_per_word / 2;

    // One enable per byte lane
    typedef logic [bytes_per_word-1:0] byte_en_t;

    ////////////////////////////////////////
    // Store data lanes
    ////////////////////////////////////////

    // Same word seen as bytes or as halfwords
    typedef union packed {
        logic [bytes_per_word-1:0][7:0]   bytes;
        logic [halves_per_word-1:0][15:0] halves;
    } store_word_u;

endpackage

/* hdl/mem_access_unit.sv */
`timescale 1ns/100ps

module mem_access_unit
    import exec_ops_pkg::*;
    import mem_access_pkg::*;
(
    input  logic [xlen-1:0] first_operand_i,
    input  logic [xlen-1:0] second_operand_i,
    input  logic [xlen-1:0] third_operand_i,
    input  op_e             operation_i,
    mem_req_if.source       req
);

    logic [xlen-1:0]             effective_address;
    logic [word_offset_bits-1:0] offset;
    store_word_u                 store_lanes;

    ////////////////////////////////////////
    // Address
    ////////////////////////////////////////

    // Base register plus immediate
    assign effective_address = first_operand_i + second_operand_i;
    assign offset            = effective_address[word_offset_bits-1:0];

    assign req.effective_address = effective_address;
    assign req.address = {effective_address[xlen-1:word_offset_bits],
                          {word_offset_bits{1'b0}}};

    assign req.read_enable = operation_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            SB:      req.write_enable = byte_en_t'(1) << offset;
            SH:      req.write_enable = offset[1] ? byte_en_t'(4'b1100) : byte_en_t'(4'b0011);
            SW:      req.write_enable = '1;
            default: req.write_enable = '0;
        endcase
    end

    ////////////////////////////////////////
    // Store data
    ////////////////////////////////////////

    // Data is copied to every lane, enables pick the live ones
    always_comb begin
        store_lanes.bytes = third_operand_i;
        unique case (operation_i)
            SB: begin
                for (int i = 0; i < bytes_per_word; i++) begin
                    store_lanes.bytes[i] = third_operand_i[7:0];
                end
            end
            SH: begin
                for (int i = 0; i < halves_per_word; i++) begin
                    store_lanes.halves[i] = third_operand_i[15:0];
                end
            end
            default: begin
            end
        endcase
    end

    assign req.write_data = store_lanes.bytes;

    no_read_and_write: assert final (!(req.read_enable && req.write_enable != '0))
        else $error("Load and store requested together");

endmodule

/* hdl/mem_req_if.sv */
`timescale 1ns/100ps

interface mem_req_if
    import exec_ops_pkg::*;
    import mem_access_pkg::*;
();

    logic [xlen-1:0] address;
    logic            read_enable;
    byte_en_t        write_enable;
    logic [xlen-1:0] write_data;
    // Unaligned sum, kept for the load/store result
    logic [xlen-1:0] effective_address;

    modport source (
        output address, read_enable, write_enable, write_data, effective_address
    );

    modport sink (
        input address, read_enable, write_enable, write_data, effective_address
    );

endinterface

/* hdl/retire_control.sv */
`timescale 1ns/100ps

module retire_control
    import exec_ops_pkg::*;
#(
    parameter int unsigned TAG_WIDTH = 3
)
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 stall_i,
    input  op_e                  operation_i,
    input  logic [TAG_WIDTH-1:0] tag_i,
    input  priv_e                privilege_i,
    input  logic                 exc_illegal_inst_i,
    input  logic                 exc_misaligned_fetch_i,
    input  logic                 exc_load_access_fault_i,
    int_result_if.sink           res,
    mem_req_if.sink              req,
    output logic                 killed_o,
    output logic                 jump_o,
    output logic                 raise_exception_o,
    output exc_code_e            exception_code_o,
    output logic                 write_enable_o,
    output op_e                  operation_o,
    output logic [xlen-1:0]      result_o
);

    logic [TAG_WIDTH-1:0] curr_tag;
    logic                 killed;
    logic                 mem_access;
    logic                 write_enable;
    logic [xlen-1:0]      result;

    ////////////////////////////////////////
    // Tag and kill
    ////////////////////////////////////////

    // Stale tag means the instruction is on a flushed path
    assign killed   = curr_tag != tag_i;
    assign killed_o = killed;
    assign jump_o   = res.take_branch && !killed;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump_o || raise_exception_o) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Exceptions
    ////////////////////////////////////////

    assign mem_access = req.read_enable || req.write_enable != '0;

    // Highest priority first
    always_comb begin
        raise_exception_o = !killed;
        exception_code_o  = NO_EXCEPTION;
        if (killed) begin
            exception_code_o = NO_EXCEPTION;
        end else if (exc_illegal_inst_i) begin
            exception_code_o = ILLEGAL_INSTRUCTION;
        end else if (exc_misaligned_fetch_i) begin
            exception_code_o = INSTRUCTION_ADDRESS_MISALIGNED;
        end else if (operation_i == ECALL) begin
            exception_code_o = (privilege_i == USER) ? ECALL_FROM_UMODE : ECALL_FROM_MMODE;
        end else if (operation_i == EBREAK) begin
            exception_code_o = BREAKPOINT;
        end else if (exc_load_access_fault_i && mem_access) begin
            exception_code_o = LOAD_ACCESS_FAULT;
        end else begin
            raise_exception_o = 1'b0;
        end
    end

    ////////////////////////////////////////
    // Result and write-back
    ////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            JAL, JALR:                   result = res.link_value;
            LB, LBU, LH, LHU, LW,
            SB, SH, SW:                  result = req.effective_address;
            default:                     result = res.value;
        endcase
    end

    // No register write for stores and branches
    always_comb begin
        unique case (operation_i)
            NOP, SB, SH, SW,
            BEQ, BNE, BLT, BLTU,
            BGE, BGEU: write_enable = 1'b0;
            default:   write_enable = !(killed || raise_exception_o);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            operation_o    <= NOP;
            result_o       <= '0;
        end else if (stall_i) begin
            // Bubble into write-back
            write_enable_o <= 1'b0;
            operation_o    <= NOP;
            result_o       <= '0;
        end else begin
            write_enable_o <= write_enable;
            operation_o    <= operation_i;
            result_o       <= result;
        end
    end

    killed_is_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        killed_o |-> !(raise_exception_o || jump_o))
        else $error("Killed instruction raised a jump or exception");

endmodule

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Compare one DUT output with its expected value
task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
                 $time, name, actual, expected);
        report_failure();
    end
endtask

// Wait for the next rising edge, then move to the given offset after it
task automatic next_edge(input int offset);
    int unsigned start_count;
    int unsigned waited;
    start_count = edge_count;
    waited      = 0;
    while (edge_count == start_count) begin
        if (waited >= edge_timeout_ns) begin
            $display("Timed out after %0d ns waiting for a rising clock edge", waited);
            report_failure();
        end
        #1;
        waited++;
    end
    #(offset - ($time - last_edge));
endtask

// Present one instruction and let the combinational outputs settle
task automatic apply_inst(input op_e op, input logic [xlen-1:0] first,
                          input logic [xlen-1:0] second, input logic [xlen-1:0] third,
                          input logic [tag_width-1:0] tag);
    operation_i      = op;
    first_operand_i  = first;
    second_operand_i = second;
    third_operand_i  = third;
    tag_i            = tag;
    #(settle_ns);
endtask

// Close the cycle; the stage tag moves on after a jump or exception
task automatic end_cycle(input logic redirect);
    if (redirect) begin
        model_tag = model_tag + 1'b1;
    end
    next_edge(drive_offset_ns);
endtask

`endif

/* testbench/tb_execute_stage.sv */
`timescale 1ns/100ps

module tb_execute_stage
    import exec_ops_pkg::*;
    import mem_access_pkg::*;
();

    localparam int period_ns       = 100;
    localparam int drive_offset_ns = 10;
    localparam int settle_ns       = 40;
    localparam int edge_timeout_ns = 1000;
    localparam int tag_width       = 3;

    logic                 clk;
    logic                 reset_n;
    logic                 stall_i;
    logic [xlen-1:0]      pc_i;
    logic [xlen-1:0]      first_operand_i;
    logic [xlen-1:0]      second_operand_i;
    logic [xlen-1:0]      third_operand_i;
    op_e                  operation_i;
    logic                 compressed_i;
    logic [tag_width-1:0] tag_i;
    priv_e                privilege_i;
    logic                 exc_illegal_inst_i;
    logic                 exc_misaligned_fetch_i;
    logic                 exc_load_access_fault_i;
    logic                 killed_o;
    logic                 jump_o;
    logic [xlen-1:0]      jump_target_o;
    logic [xlen-1:0]      mem_address_o;
    logic                 mem_read_enable_o;
    byte_en_t             mem_write_enable_o;
    logic [xlen-1:0]      mem_write_data_o;
    logic                 raise_exception_o;
    exc_code_e            exception_code_o;
    logic                 write_enable_o;
    op_e                  operation_o;
    logic [xlen-1:0]      result_o;

    logic [tag_width-1:0] model_tag  = '0;
    integer               seed       = 32'hedddada5;
    int unsigned          edge_count = 0;
    time                  last_edge  = 0;

    execute_stage #(
        .TAG_WIDTH (tag_width)
    ) i_execute_stage (
        .clk                     (clk),
        .reset_n                 (reset_n),
        .stall_i                 (stall_i),
        .pc_i                    (pc_i),
        .first_operand_i         (first_operand_i),
        .second_operand_i        (second_operand_i),
        .third_operand_i         (third_operand_i),
        .operation_i             (operation_i),
        .compressed_i            (compressed_i),
        .tag_i                   (tag_i),
        .privilege_i             (privilege_i),
        .exc_illegal_inst_i      (exc_illegal_inst_i),
        .exc_misaligned_fetch_i  (exc_misaligned_fetch_i),
        .exc_load_access_fault_i (exc_load_access_fault_i),
        .killed_o                (killed_o),
        .jump_o                  (jump_o),
        .jump_target_o           (jump_target_o),
        .mem_address_o           (mem_address_o),
        .mem_read_enable_o       (mem_read_enable_o),
        .mem_write_enable_o      (mem_write_enable_o),
        .mem_write_data_o        (mem_write_data_o),
        .raise_exception_o       (raise_exception_o),
        .exception_code_o        (exception_code_o),
        .write_enable_o          (write_enable_o),
        .operation_o             (operation_o),
        .result_o                (result_o)
    );

    always #(period_ns / 2) clk = ~clk;

    // Edge bookkeeping for the timed waits
    always @(posedge clk) begin
        edge_count = edge_count + 1;
        last_edge  = $time;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////

    function automatic logic [xlen-1:0] alu_expect(input op_e op, input logic [xlen-1:0] a,
                                                   input logic [xlen-1:0] b);
        case (op)
            LUI:     return b;
            ADD:     return a + b;
            SUB:     return a - b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            XOR:     return a ^ b;
            OR:      return a | b;
            AND:     return a & b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $unsigned($signed(a) >>> b[4:0]);
            default: return 'x;
        endcase
    endfunction

    function automatic logic branch_taken(input op_e op, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic exercise_alu();
        op_e             alu_ops[11] = '{LUI, ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA};
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        repeat (3) begin
            for (int i = 0; i < 11; i++) begin
                a = $random(seed);
                b = $random(seed);
                apply_inst(alu_ops[i], a, b, 32'h0, model_tag);
                check_value("raise_exception_o", raise_exception_o, 1'b0);
                end_cycle(1'b0);
                check_value("result_o", result_o, alu_expect(alu_ops[i], a, b));
                check_value("write_enable_o", write_enable_o, 1'b1);
                check_value("operation_o", operation_o, alu_ops[i]);
            end
        end
    endtask

    task automatic jump_case(input op_e op, input logic compressed);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] target;
        a            = $random(seed);
        b            = $random(seed);
        pc_i         = $random(seed) & 32'hffff_fffe;
        compressed_i = compressed;
        target       = a + b;
        if (op == JALR) begin
            target[0] = 1'b0;
        end
        apply_inst(op, a, b, 32'h0, model_tag);
        check_value("jump_o", jump_o, 1'b1);
        check_value("jump_target_o", jump_target_o, target);
        end_cycle(1'b1);
        // Link skips the instruction just executed
        check_value("result_o", result_o, pc_i + (compressed ? 32'd2 : 32'd4));
        check_value("write_enable_o", write_enable_o, 1'b1);
    endtask

    task automatic branches_and_jumps();
        op_e             branch_ops[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        // Equal, less, and pairs where signed and unsigned order disagree
        logic [xlen-1:0] lhs[4] = '{32'd5, 32'd1, 32'hffff_fffd, 32'd4};
        logic [xlen-1:0] rhs[4] = '{32'd5, 32'd2, 32'd4, 32'hffff_fffd};
        logic [xlen-1:0] offset;
        logic            taken;
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 4; p++) begin
                pc_i   = $random(seed) & 32'hffff_fffe;
                offset = $random(seed) & 32'h0000_0ffe;
                taken  = branch_taken(branch_ops[i], lhs[p], rhs[p]);
                apply_inst(branch_ops[i], lhs[p], rhs[p], offset, model_tag);
                check_value("jump_o", jump_o, taken);
                check_value("jump_target_o", jump_target_o, pc_i + offset);
                end_cycle(taken);
                check_value("write_enable_o", write_enable_o, 1'b0);
            end
        end
        jump_case(JAL, 1'b0);
        jump_case(JAL, 1'b1);
        jump_case(JALR, 1'b0);
        jump_case(JALR, 1'b1);
        compressed_i = 1'b0;
    endtask

    task automatic loads_and_stores();
        op_e             store_ops[3] = '{SB, SH, SW};
        op_e             load_ops[5]  = '{LB, LBU, LH, LHU, LW};
        logic [xlen-1:0] base;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
        logic [xlen-1:0] exp_data;
        logic [3:0]      exp_en;
        for (int off = 0; off < 4; off++) begin
            base = $random(seed) & 32'hffff_fffc;
            imm  = ($random(seed) & 32'hffff_fffc) | off;
            addr = base + imm;
            data = $random(seed);
            for (int s = 0; s < 3; s++) begin
                exp_en   = 4'b1111;
                exp_data = data;
                if (store_ops[s] == SB) begin
                    exp_en   = 4'b0001 << off;
                    exp_data = {4{data[7:0]}};
                end else if (store_ops[s] == SH) begin
                    exp_en   = (off >= 2) ? 4'b1100 : 4'b0011;
                    exp_data = {2{data[15:0]}};
                end
                apply_inst(store_ops[s], base, imm, data, model_tag);
                check_value("mem_address_o", mem_address_o, addr & 32'hffff_fffc);
                check_value("mem_read_enable_o", mem_read_enable_o, 1'b0);
                check_value("mem_write_enable_o", mem_write_enable_o, exp_en);
                check_value("mem_write_data_o", mem_write_data_o, exp_data);
                end_cycle(1'b0);
                check_value("write_enable_o", write_enable_o, 1'b0);
            end
            for (int l = 0; l < 5; l++) begin
                apply_inst(load_ops[l], base, imm, data, model_tag);
                check_value("mem_address_o", mem_address_o, addr & 32'hffff_fffc);
                check_value("mem_read_enable_o", mem_read_enable_o, 1'b1);
                check_value("mem_write_enable_o", mem_write_enable_o, 4'b0000);
                end_cycle(1'b0);
                check_value("result_o", result_o, addr);
                check_value("write_enable_o", write_enable_o, 1'b1);
            end
        end
    endtask

    task automatic kill_after_jump();
        logic [tag_width-1:0] old_tag;
        logic [xlen-1:0]      a;
        logic [xlen-1:0]      b;
        old_tag = model_tag;
        pc_i    = 32'h0000_2000;
        apply_inst(JAL, 32'h0000_0100, 32'h0000_0020, 32'h0, model_tag);
        check_value("jump_o", jump_o, 1'b1);
        end_cycle(1'b1);
        // Wrong-path jump with a pending cause stays silent
        exc_illegal_inst_i = 1'b1;
        apply_inst(JAL, 32'h0000_0100, 32'h0000_0020, 32'h0, old_tag);
        check_value("killed_o", killed_o, 1'b1);
        check_value("jump_o", jump_o, 1'b0);
        check_value("raise_exception_o", raise_exception_o, 1'b0);
        end_cycle(1'b0);
        check_value("write_enable_o", write_enable_o, 1'b0);
        exc_illegal_inst_i = 1'b0;
        a = $random(seed);
        b = $random(seed);
        apply_inst(ADD, a, b, 32'h0, model_tag);
        check_value("killed_o", killed_o, 1'b0);
        end_cycle(1'b0);
        check_value("write_enable_o", write_enable_o, 1'b1);
        check_value("result_o", result_o, a + b);
    endtask

    // Causes are {illegal, misaligned fetch, load fault}
    task automatic exception_case(input op_e op, input logic [2:0] causes, input priv_e priv,
                                  input exc_code_e expected);
        logic raised;
        raised      = expected != NO_EXCEPTION;
        privilege_i = priv;
        {exc_illegal_inst_i, exc_misaligned_fetch_i, exc_load_access_fault_i} = causes;
        apply_inst(op, 32'h0000_0400, 32'h0000_0010, 32'h0, model_tag);
        check_value("killed_o", killed_o, 1'b0);
        check_value("raise_exception_o", raise_exception_o, raised);
        check_value("exception_code_o", exception_code_o, expected);
        end_cycle(raised);
        check_value("write_enable_o", write_enable_o, (op != SW) && !raised);
    endtask

    task automatic exception_causes();
        exception_case(ADD, 3'b100, MACHINE, ILLEGAL_INSTRUCTION);
        exception_case(ADD, 3'b010, MACHINE, INSTRUCTION_ADDRESS_MISALIGNED);
        exception_case(ECALL, 3'b000, USER, ECALL_FROM_UMODE);
        exception_case(ECALL, 3'b000, MACHINE, ECALL_FROM_MMODE);
        exception_case(EBREAK, 3'b000, MACHINE, BREAKPOINT);
        exception_case(LW, 3'b001, MACHINE, LOAD_ACCESS_FAULT);
        exception_case(SW, 3'b001, MACHINE, LOAD_ACCESS_FAULT);
        exception_case(ADD, 3'b001, MACHINE, NO_EXCEPTION);
        // Several causes at once
        exception_case(ECALL, 3'b111, USER, ILLEGAL_INSTRUCTION);
        exception_case(LW, 3'b011, MACHINE, INSTRUCTION_ADDRESS_MISALIGNED);
        exception_case(ECALL, 3'b010, USER, INSTRUCTION_ADDRESS_MISALIGNED);
        exception_case(EBREAK, 3'b010, MACHINE, INSTRUCTION_ADDRESS_MISALIGNED);
        exception_case(ECALL, 3'b001, USER, ECALL_FROM_UMODE);
        exception_case(EBREAK, 3'b001, MACHINE, BREAKPOINT);
        {exc_illegal_inst_i, exc_misaligned_fetch_i, exc_load_access_fault_i} = 3'b000;
        privilege_i = MACHINE;
    endtask

    task automatic stall_bubble();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        a       = $random(seed);
        b       = $random(seed);
        stall_i = 1'b1;
        apply_inst(ADD, a, b, 32'h0, model_tag);
        end_cycle(1'b0);
        check_value("write_enable_o", write_enable_o, 1'b0);
        check_value("operation_o", operation_o, NOP);
        check_value("result_o", result_o, 32'h0);
        stall_i = 1'b0;
        apply_inst(SUB, a, b, 32'h0, model_tag);
        end_cycle(1'b0);
        check_value("write_enable_o", write_enable_o, 1'b1);
        check_value("operation_o", operation_o, SUB);
        check_value("result_o", result_o, a - b);
    endtask

    initial begin
        clk                     = 1'b0;
        reset_n                 = 1'b0;
        stall_i                 = 1'b0;
        pc_i                    = '0;
        first_operand_i         = '0;
        second_operand_i        = '0;
        third_operand_i         = '0;
        operation_i             = NOP;
        compressed_i            = 1'b0;
        tag_i                   = '0;
        privilege_i             = MACHINE;
        exc_illegal_inst_i      = 1'b0;
        exc_misaligned_fetch_i  = 1'b0;
        exc_load_access_fault_i = 1'b0;
        repeat (5) next_edge(drive_offset_ns);
        reset_n = 1'b1;
        check_value("write_enable_o", write_enable_o, 1'b0);
        check_value("operation_o", operation_o, NOP);
        check_value("result_o", result_o, 32'h0);
        check_value("killed_o", killed_o, 1'b0);
        exercise_alu();
        branches_and_jumps();
        loads_and_stores();
        kill_after_jump();
        exception_causes();
        stall_bubble();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hdl/exec_ops_pkg.sv
hdl/mem_access_pkg.sv
hdl/int_result_if.sv
hdl/mem_req_if.sv
hdl/integer_unit.sv
hdl/mem_access_unit.sv
hdl/retire_control.sv
hdl/execute_stage.sv
testbench/tb_execute_stage.sv
